// File: common/muldiv_consts.svh
//####################
// muldiv constants
// word widths and iteration count of the mul/div cluster
//####################
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// data word width
`define MD_XLEN 32

// register file address width
`define MD_RADDR_W 5

// one result bit per iteration
`define MD_ITER 32

`endif

// File: common/muldiv_pkg.sv
//####################
// muldiv_pkg
// op codes of the mul/div units and the write-back source id
//####################
package muldiv_pkg;

    // one-hot divider ops
    typedef enum logic [3:0] {
        DIV  = 4'b0001,
        DIVU = 4'b0010,
        REM  = 4'b0100,
        REMU = 4'b1000
    } div_op_t;

    // one-hot multiplier ops
    typedef enum logic [3:0] {
        MUL    = 4'b0001,
        MULH   = 4'b0010,
        MULHSU = 4'b0100,
        MULHU  = 4'b1000
    } mul_op_t;

    typedef enum logic {
        SRC_MUL = 1'b0,
        SRC_DIV = 1'b1
    } wb_src_t;  // last write-back grant

endpackage

// File: div/exu_div.sv
//####################
// exu_div
// iterative RV32 divider, one quotient bit per cycle by trial subtraction
// start is held for the whole operation, dropping it aborts
//####################
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module exu_div (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     start_i,     // held until ready
    input  muldiv_pkg::div_op_t      op_i,
    input  logic [`MD_XLEN-1:0]      dividend_i,
    input  logic [`MD_XLEN-1:0]      divisor_i,
    input  logic [`MD_RADDR_W-1:0]   waddr_i,
    output logic [`MD_XLEN-1:0]      result_o,
    output logic                     ready_o,     // one-cycle pulse
    output logic                     busy_o,
    output logic [`MD_RADDR_W-1:0]   waddr_o
);

    localparam int CNT_W = $clog2(`MD_ITER);

    typedef enum logic [3:0] {
        ST_IDLE  = 4'b0001,
        ST_START = 4'b0010,
        ST_CALC  = 4'b0100,
        ST_END   = 4'b1000
    } state_t;

    state_t                  state;
    logic [CNT_W-1:0]        cnt;
    muldiv_pkg::div_op_t     op_r;
    logic [`MD_XLEN-1:0]     dvd_r;       // dividend, quotient shifts in from the right
    logic [`MD_XLEN-1:0]     dsr_r;
    logic [`MD_XLEN-1:0]     rem_r;       // partial remainder
    logic                    inv_r;       // negate result at the end

    logic                    is_signed;
    logic                    want_quot;
    logic                    dvd_neg;
    logic                    dsr_neg;
    logic [`MD_XLEN:0]       trial;
    logic [`MD_XLEN:0]       trial_diff;
    logic                    trial_ge;
    logic [`MD_XLEN-1:0]     sel_val;

    assign is_signed = (op_r == muldiv_pkg::DIV) || (op_r == muldiv_pkg::REM);
    assign want_quot = (op_r == muldiv_pkg::DIV) || (op_r == muldiv_pkg::DIVU);
    assign dvd_neg   = is_signed & dvd_r[`MD_XLEN-1];
    assign dsr_neg   = is_signed & dsr_r[`MD_XLEN-1];

    // next remainder candidate, borrow bit tells whether the divisor fits
    assign trial      = {rem_r, dvd_r[`MD_XLEN-1]};
    assign trial_diff = trial - {1'b0, dsr_r};
    assign trial_ge   = ~trial_diff[`MD_XLEN];

    assign sel_val = want_quot ? dvd_r : rem_r;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            if (state != ST_IDLE && !start_i) begin
                state  <= ST_IDLE;  // abort, no ready
                busy_o <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_i) begin
                            state  <= ST_START;
                            busy_o <= 1'b1;
                        end
                    end
                    ST_START: begin
                        if (dsr_r == '0) begin
                            state   <= ST_IDLE;  // divide by zero, done at once
                            busy_o  <= 1'b0;
                            ready_o <= 1'b1;
                        end else begin
                            state <= ST_CALC;
                            cnt   <= CNT_W'(`MD_ITER - 1);
                        end
                    end
                    ST_CALC: begin
                        if (cnt == '0) begin
                            state <= ST_END;
                        end
                        cnt <= cnt - 1'b1;
                    end
                    ST_END: begin
                        state   <= ST_IDLE;
                        busy_o  <= 1'b0;
                        ready_o <= 1'b1;
                    end
                    default: begin
                        state  <= ST_IDLE;
                        busy_o <= 1'b0;
                    end
                endcase
            end
        end
    end

    // operand and result path
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start_i) begin
                    op_r    <= op_i;
                    dvd_r   <= dividend_i;
                    dsr_r   <= divisor_i;
                    waddr_o <= waddr_i;
                end
            end
            ST_START: begin
                rem_r <= '0;
                // quotient sign from both operands, remainder takes the dividend's
                inv_r <= want_quot ? (dvd_neg ^ dsr_neg) : dvd_neg;
                if (dvd_neg) begin
                    dvd_r <= -dvd_r;
                end
                if (dsr_neg) begin
                    dsr_r <= -dsr_r;
                end
                if (dsr_r == '0) begin
                    result_o <= want_quot ? '1 : dvd_r;  // RV32 div by zero
                end
            end
            ST_CALC: begin
                dvd_r <= {dvd_r[`MD_XLEN-2:0], trial_ge};
                rem_r <= trial_ge ? trial_diff[`MD_XLEN-1:0] : trial[`MD_XLEN-1:0];
            end
            ST_END: begin
                result_o <= inv_r ? -sel_val : sel_val;
            end
            default: ;
        endcase
    end

endmodule

// File: mul/exu_mul.sv
//####################
// exu_mul
// iterative shift-add multiplier, low or high product word with sign fix
//####################
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module exu_mul (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     start_i,     // held until ready
    input  muldiv_pkg::mul_op_t      op_i,
    input  logic [`MD_XLEN-1:0]      a_i,
    input  logic [`MD_XLEN-1:0]      b_i,
    input  logic [`MD_RADDR_W-1:0]   waddr_i,
    output logic [`MD_XLEN-1:0]      result_o,
    output logic                     ready_o,
    output logic                     busy_o,
    output logic [`MD_RADDR_W-1:0]   waddr_o
);

    localparam int CNT_W = $clog2(`MD_ITER);

    typedef enum logic [2:0] {
        ST_IDLE = 3'b001,
        ST_CAP  = 3'b010,
        ST_CALC = 3'b100
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         cnt;
    muldiv_pkg::mul_op_t      op_r;
    logic [`MD_XLEN-1:0]      a_r;        // multiplicand
    logic [`MD_XLEN-1:0]      b_r;
    logic [2*`MD_XLEN-1:0]    prod_r;     // {acc, multiplier bits still to use}
    logic                     neg_r;

    logic                     a_neg;
    logic                     b_neg;
    logic [`MD_XLEN:0]        part_sum;
    logic [2*`MD_XLEN-1:0]    prod_next;
    logic [2*`MD_XLEN-1:0]    prod_fix;

    // MUL low word is sign independent, handled as unsigned
    assign a_neg = ((op_r == muldiv_pkg::MULH) || (op_r == muldiv_pkg::MULHSU)) & a_r[`MD_XLEN-1];
    assign b_neg = (op_r == muldiv_pkg::MULH) & b_r[`MD_XLEN-1];

    assign part_sum  = {1'b0, prod_r[2*`MD_XLEN-1:`MD_XLEN]} + (prod_r[0] ? {1'b0, a_r} : '0);
    assign prod_next = {part_sum, prod_r[`MD_XLEN-1:1]};
    assign prod_fix  = neg_r ? -prod_next : prod_next;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            if (state != ST_IDLE && !start_i) begin
                state  <= ST_IDLE;  // abort
                busy_o <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_i) begin
                            state  <= ST_CAP;
                            busy_o <= 1'b1;
                        end
                    end
                    ST_CAP: begin
                        state <= ST_CALC;
                        cnt   <= CNT_W'(`MD_ITER - 1);
                    end
                    ST_CALC: begin
                        if (cnt == '0) begin
                            state   <= ST_IDLE;
                            busy_o  <= 1'b0;
                            ready_o <= 1'b1;
                        end
                        cnt <= cnt - 1'b1;
                    end
                    default: begin
                        state  <= ST_IDLE;
                        busy_o <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start_i) begin
                    op_r    <= op_i;
                    a_r     <= a_i;
                    b_r     <= b_i;
                    waddr_o <= waddr_i;
                end
            end
            ST_CAP: begin
                a_r    <= a_neg ? -a_r : a_r;  // magnitudes only from here on
                prod_r <= {{`MD_XLEN{1'b0}}, (b_neg ? -b_r : b_r)};
                neg_r  <= a_neg ^ b_neg;
            end
            ST_CALC: begin
                prod_r <= prod_next;
                if (cnt == '0) begin
                    result_o <= (op_r == muldiv_pkg::MUL) ? prod_fix[`MD_XLEN-1:0]
                                                          : prod_fix[2*`MD_XLEN-1:`MD_XLEN];
                end
            end
            default: ;
        endcase
    end

endmodule

// File: src/wb_arbiter.sv
//####################
// wb_arbiter
// one pending result per unit onto the shared register write port
// ties go to the unit not granted last
//####################
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module wb_arbiter (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     mul_ready_i,
    input  logic [`MD_XLEN-1:0]      mul_result_i,
    input  logic [`MD_RADDR_W-1:0]   mul_waddr_i,
    input  logic                     div_ready_i,
    input  logic [`MD_XLEN-1:0]      div_result_i,
    input  logic [`MD_RADDR_W-1:0]   div_waddr_i,
    output logic                     wb_we_o,
    output logic [`MD_RADDR_W-1:0]   wb_waddr_o,
    output logic [`MD_XLEN-1:0]      wb_wdata_o,
    output muldiv_pkg::wb_src_t      wb_src_o     // last grant
);

    logic                    mul_pend;
    logic                    div_pend;
    logic [`MD_XLEN-1:0]     mul_data;
    logic [`MD_XLEN-1:0]     div_data;
    logic [`MD_RADDR_W-1:0]  mul_addr;
    logic [`MD_RADDR_W-1:0]  div_addr;
    logic                    mul_req;
    logic                    div_req;
    logic                    mul_gnt;
    logic                    div_gnt;

    // a fresh ready can go out directly when the port is free
    assign mul_req = mul_ready_i | mul_pend;
    assign div_req = div_ready_i | div_pend;
    assign mul_gnt = mul_req & (!div_req || wb_src_o == muldiv_pkg::SRC_DIV);
    assign div_gnt = div_req & !mul_gnt;

    always_ff @(posedge clk) begin
        if (mul_ready_i) begin
            mul_data <= mul_result_i;
            mul_addr <= mul_waddr_i;
        end
        if (div_ready_i) begin
            div_data <= div_result_i;
            div_addr <= div_waddr_i;
        end
        if (mul_gnt) begin
            wb_wdata_o <= mul_ready_i ? mul_result_i : mul_data;
            wb_waddr_o <= mul_ready_i ? mul_waddr_i : mul_addr;
        end else if (div_gnt) begin
            wb_wdata_o <= div_ready_i ? div_result_i : div_data;
            wb_waddr_o <= div_ready_i ? div_waddr_i : div_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mul_pend <= 1'b0;
            div_pend <= 1'b0;
            wb_we_o  <= 1'b0;
            wb_src_o <= muldiv_pkg::SRC_DIV;  // mul wins the first tie
        end else begin
            mul_pend <= mul_req & ~mul_gnt;   // loser waits one cycle
            div_pend <= div_req & ~div_gnt;
            wb_we_o  <= mul_gnt | div_gnt;
            if (mul_gnt) begin
                wb_src_o <= muldiv_pkg::SRC_MUL;
            end else if (div_gnt) begin
                wb_src_o <= muldiv_pkg::SRC_DIV;
            end
        end
    end

endmodule

// File: src/exu_muldiv.sv
//####################
// exu_muldiv
// mul/div execution cluster, both units share one write-back port
//####################
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module exu_muldiv (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     div_start_i,
    input  muldiv_pkg::div_op_t      div_op_i,
    input  logic [`MD_XLEN-1:0]      div_a_i,
    input  logic [`MD_XLEN-1:0]      div_b_i,
    input  logic [`MD_RADDR_W-1:0]   div_waddr_i,
    input  logic                     mul_start_i,
    input  muldiv_pkg::mul_op_t      mul_op_i,
    input  logic [`MD_XLEN-1:0]      mul_a_i,
    input  logic [`MD_XLEN-1:0]      mul_b_i,
    input  logic [`MD_RADDR_W-1:0]   mul_waddr_i,
    output logic                     div_busy_o,
    output logic                     mul_busy_o,
    output logic                     wb_we_o,
    output logic [`MD_RADDR_W-1:0]   wb_waddr_o,
    output logic [`MD_XLEN-1:0]      wb_wdata_o,
    output muldiv_pkg::wb_src_t      wb_src_o
);

    logic [`MD_XLEN-1:0]     div_result;
    logic                    div_ready;
    logic [`MD_RADDR_W-1:0]  div_waddr;
    logic [`MD_XLEN-1:0]     mul_result;
    logic                    mul_ready;
    logic [`MD_RADDR_W-1:0]  mul_waddr;

    exu_div u_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start_i),
        .op_i       (div_op_i),
        .dividend_i (div_a_i),
        .divisor_i  (div_b_i),
        .waddr_i    (div_waddr_i),
        .result_o   (div_result),
        .ready_o    (div_ready),
        .busy_o     (div_busy_o),
        .waddr_o    (div_waddr)
    );

    exu_mul u_mul (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mul_start_i),
        .op_i     (mul_op_i),
        .a_i      (mul_a_i),
        .b_i      (mul_b_i),
        .waddr_i  (mul_waddr_i),
        .result_o (mul_result),
        .ready_o  (mul_ready),
        .busy_o   (mul_busy_o),
        .waddr_o  (mul_waddr)
    );

    wb_arbiter u_arb (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mul_ready_i  (mul_ready),
        .mul_result_i (mul_result),
        .mul_waddr_i  (mul_waddr),
        .div_ready_i  (div_ready),
        .div_result_i (div_result),
        .div_waddr_i  (div_waddr),
        .wb_we_o      (wb_we_o),
        .wb_waddr_o   (wb_waddr_o),
        .wb_wdata_o   (wb_wdata_o),
        .wb_src_o     (wb_src_o)
    );

endmodule

// File: test/exu_muldiv_assertions.sv
//####################
// exu_muldiv_assertions
// protocol checks on the unit strobes and the shared write port
//####################
`timescale 1ns/1ns

module exu_muldiv_assertions (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 div_ready_i,
    input  logic                 mul_ready_i,
    input  logic                 div_busy_i,
    input  logic                 mul_busy_i,
    input  logic                 wb_we_i,
    input  muldiv_pkg::wb_src_t  wb_src_i
);

    logic seen_ready;  // any ready since reset
    logic sva_fail = 1'b0;  // sticky, read by the testbench

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seen_ready <= 1'b0;
        end else if (div_ready_i || mul_ready_i) begin
            seen_ready <= 1'b1;
        end
    end

    // every write cycle is owed to a ready one or two cycles back
    a_we_per_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_we_i |-> ($past(mul_ready_i) || $past(div_ready_i) ||
                     ($past(mul_ready_i, 2) && $past(div_ready_i, 2))))
        else begin
            sva_fail = 1'b1;
            $error("write port active without a matching ready");
        end

    a_busy_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(div_busy_i && div_ready_i) && !(mul_busy_i && mul_ready_i))
        else begin
            sva_fail = 1'b1;
            $error("busy and ready high together");
        end

    a_no_early_we: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_we_i |-> seen_ready)
        else begin
            sva_fail = 1'b1;
            $error("write port active before any ready");
        end

    a_div_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(div_ready_i, 2) |-> ((wb_we_i && wb_src_i == muldiv_pkg::SRC_DIV) ||
            ($past(wb_we_i) && $past(wb_src_i) == muldiv_pkg::SRC_DIV)))
        else begin
            sva_fail = 1'b1;
            $error("divider result not written within 2 cycles");
        end

    a_mul_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(mul_ready_i, 2) |-> ((wb_we_i && wb_src_i == muldiv_pkg::SRC_MUL) ||
            ($past(wb_we_i) && $past(wb_src_i) == muldiv_pkg::SRC_MUL)))
        else begin
            sva_fail = 1'b1;
            $error("multiplier result not written within 2 cycles");
        end

endmodule

bind exu_muldiv exu_muldiv_assertions u_sva (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .div_ready_i (div_ready),
    .mul_ready_i (mul_ready),
    .div_busy_i  (div_busy_o),
    .mul_busy_i  (mul_busy_o),
    .wb_we_i     (wb_we_o),
    .wb_src_i    (wb_src_o)
);

// File: test/tb_exu_muldiv.sv
//####################
// tb_exu_muldiv
// table driven testbench for the mul/div cluster with a RISC-V reference model
//####################
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module tb_exu_muldiv;

    localparam int N_ROWS = 30;
    localparam int LIMIT  = N_ROWS * 40 + 100;

    logic                      clk;
    logic                      arst_n_i;
    logic                      div_start_i;
    muldiv_pkg::div_op_t       div_op_i;
    logic [`MD_XLEN-1:0]       div_a_i;
    logic [`MD_XLEN-1:0]       div_b_i;
    logic [`MD_RADDR_W-1:0]    div_waddr_i;
    logic                      mul_start_i;
    muldiv_pkg::mul_op_t       mul_op_i;
    logic [`MD_XLEN-1:0]       mul_a_i;
    logic [`MD_XLEN-1:0]       mul_b_i;
    logic [`MD_RADDR_W-1:0]    mul_waddr_i;
    logic                      div_busy_o;
    logic                      mul_busy_o;
    logic                      wb_we_o;
    logic [`MD_RADDR_W-1:0]    wb_waddr_o;
    logic [`MD_XLEN-1:0]       wb_wdata_o;
    muldiv_pkg::wb_src_t       wb_src_o;

    // stimulus table, kind 0 div, 1 mul, 2 both together
    int                        row_kind  [N_ROWS];
    muldiv_pkg::div_op_t       row_dop   [N_ROWS];
    muldiv_pkg::mul_op_t       row_mop   [N_ROWS];
    logic [31:0]               row_a     [N_ROWS];
    logic [31:0]               row_b     [N_ROWS];
    logic [4:0]                row_waddr [N_ROWS];
    logic                      row_abort [N_ROWS];
    int                        n_rows;

    logic [31:0]               lfsr;
    int                        cycles;
    int                        fail_count;
    muldiv_pkg::wb_src_t       last_src;  // model of the arbiter's last grant

    exu_muldiv u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("Test FAILED");
            $fatal(1, "stopped on timeout");
        end else if (u_dut.u_sva.sva_fail) begin
            $display("assertion in the bound checker failed at time %0t", $time);
            $display("Test FAILED");
            $fatal(1, "stopped on assertion");
        end
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // RISC-V M extension divide rules
    function automatic logic [31:0] div_model(input muldiv_pkg::div_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic quot;
        logic sgn;
        quot = (op == muldiv_pkg::DIV) || (op == muldiv_pkg::DIVU);
        sgn  = (op == muldiv_pkg::DIV) || (op == muldiv_pkg::REM);
        if (b == 32'd0) begin
            return quot ? 32'hffff_ffff : a;
        end
        if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return quot ? a : 32'd0;  // overflow case
        end
        if (sgn) begin
            return quot ? 32'($signed(a) / $signed(b)) : 32'($signed(a) % $signed(b));
        end
        return quot ? a / b : a % b;
    endfunction

    function automatic logic [31:0] mul_model(input muldiv_pkg::mul_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        xa = (op == muldiv_pkg::MULH || op == muldiv_pkg::MULHSU) ?
             {{32{a[31]}}, a} : {32'd0, a};
        xb = (op == muldiv_pkg::MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        p  = xa * xb;  // mod 2^64 is enough for either word
        return (op == muldiv_pkg::MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Test FAILED");
        $fatal(1, "stopped on error");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped on mismatch");
        end
    endtask

    task automatic add_row(input int kind, input muldiv_pkg::div_op_t dop,
                           input muldiv_pkg::mul_op_t mop, input logic [31:0] a,
                           input logic [31:0] b, input logic abort);
        row_kind[n_rows]  = kind;
        row_dop[n_rows]   = dop;
        row_mop[n_rows]   = mop;
        row_a[n_rows]     = a;
        row_b[n_rows]     = b;
        row_waddr[n_rows] = 5'(n_rows + 1);
        row_abort[n_rows] = abort;
        n_rows++;
    endtask

    task automatic wait_write();
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_we_o && n < 3) begin
            n++;
            @(negedge clk);
        end
        if (!wb_we_o) begin
            stop_with_error("no register write after ready");
        end
    endtask

    task automatic check_write(input muldiv_pkg::wb_src_t src, input logic [31:0] data,
                               input logic [4:0] addr);
        check("write source", 32'(wb_src_o), 32'(src));
        check("write data", wb_wdata_o, data);
        check("write address", 32'(wb_waddr_o), 32'(addr));
    endtask

    task automatic run_div(input int r);
        int lat;
        lat = (row_b[r] == 32'd0) ? 2 : 35;
        @(posedge clk);
        div_start_i <= 1'b1;
        div_op_i    <= row_dop[r];
        div_a_i     <= row_a[r];
        div_b_i     <= row_b[r];
        div_waddr_i <= row_waddr[r];
        repeat (lat) @(posedge clk);
        div_start_i <= 1'b0;  // drops on the edge that raises ready
        @(negedge clk);
        check("div ready timing", 32'(u_dut.u_div.ready_o), 32'd1);
        wait_write();
        check_write(muldiv_pkg::SRC_DIV, div_model(row_dop[r], row_a[r], row_b[r]),
                    row_waddr[r]);
        last_src = muldiv_pkg::SRC_DIV;
    endtask

    task automatic run_mul(input int r);
        @(posedge clk);
        mul_start_i <= 1'b1;
        mul_op_i    <= row_mop[r];
        mul_a_i     <= row_a[r];
        mul_b_i     <= row_b[r];
        mul_waddr_i <= row_waddr[r];
        repeat (34) @(posedge clk);
        mul_start_i <= 1'b0;
        @(negedge clk);
        check("mul ready timing", 32'(u_dut.u_mul.ready_o), 32'd1);
        wait_write();
        check_write(muldiv_pkg::SRC_MUL, mul_model(row_mop[r], row_a[r], row_b[r]),
                    row_waddr[r]);
        last_src = muldiv_pkg::SRC_MUL;
    endtask

    // divider one cycle ahead so both ready pulses land together
    task automatic run_both(input int r);
        logic [31:0] dexp;
        logic [31:0] mexp;
        logic [4:0]  maddr;
        dexp  = div_model(row_dop[r], row_a[r], row_b[r]);
        mexp  = mul_model(row_mop[r], row_a[r], row_b[r]);
        maddr = row_waddr[r] + 5'd1;
        @(posedge clk);
        div_start_i <= 1'b1;
        div_op_i    <= row_dop[r];
        div_a_i     <= row_a[r];
        div_b_i     <= row_b[r];
        div_waddr_i <= row_waddr[r];
        @(posedge clk);
        mul_start_i <= 1'b1;
        mul_op_i    <= row_mop[r];
        mul_a_i     <= row_a[r];
        mul_b_i     <= row_b[r];
        mul_waddr_i <= maddr;
        repeat (34) @(posedge clk);
        div_start_i <= 1'b0;
        mul_start_i <= 1'b0;
        @(negedge clk);
        check("tie div ready", 32'(u_dut.u_div.ready_o), 32'd1);
        check("tie mul ready", 32'(u_dut.u_mul.ready_o), 32'd1);
        wait_write();
        if (last_src == muldiv_pkg::SRC_DIV) begin
            check_write(muldiv_pkg::SRC_MUL, mexp, maddr);
            @(negedge clk);
            check("second write enable", 32'(wb_we_o), 32'd1);
            check_write(muldiv_pkg::SRC_DIV, dexp, row_waddr[r]);
            last_src = muldiv_pkg::SRC_DIV;
        end else begin
            check_write(muldiv_pkg::SRC_DIV, dexp, row_waddr[r]);
            @(negedge clk);
            check("second write enable", 32'(wb_we_o), 32'd1);
            check_write(muldiv_pkg::SRC_MUL, mexp, maddr);
            last_src = muldiv_pkg::SRC_MUL;
        end
    endtask

    task automatic run_abort(input int r);
        @(posedge clk);
        if (row_kind[r] == 0) begin
            div_start_i <= 1'b1;
            div_op_i    <= row_dop[r];
            div_a_i     <= row_a[r];
            div_b_i     <= row_b[r];
            div_waddr_i <= row_waddr[r];
        end else begin
            mul_start_i <= 1'b1;
            mul_op_i    <= row_mop[r];
            mul_a_i     <= row_a[r];
            mul_b_i     <= row_b[r];
            mul_waddr_i <= row_waddr[r];
        end
        repeat (9) @(posedge clk);
        @(negedge clk);
        check("busy before abort", 32'(div_busy_o | mul_busy_o), 32'd1);
        @(posedge clk);
        div_start_i <= 1'b0;
        mul_start_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check("busy after abort", 32'(div_busy_o | mul_busy_o), 32'd0);
        // runs past the cycle where the aborted result would have landed
        repeat (30) begin
            @(negedge clk);
            check("write after abort", 32'(wb_we_o), 32'd0);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        div_start_i = 1'b0;
        div_op_i    = muldiv_pkg::DIV;
        div_a_i     = '0;
        div_b_i     = '0;
        div_waddr_i = '0;
        mul_start_i = 1'b0;
        mul_op_i    = muldiv_pkg::MUL;
        mul_a_i     = '0;
        mul_b_i     = '0;
        mul_waddr_i = '0;
        lfsr        = 32'h72f1;
        cycles      = 0;
        fail_count  = 0;
        n_rows      = 0;
        last_src    = muldiv_pkg::SRC_DIV;

        // tie first so the mul wins after reset
        add_row(2, muldiv_pkg::DIV, muldiv_pkg::MULH, 32'hffff_fff9, 32'd3, 1'b0);
        add_row(0, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'd7, 32'd2, 1'b0);
        add_row(0, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'hffff_fff9, 32'd2, 1'b0);
        add_row(0, muldiv_pkg::REM, muldiv_pkg::MUL, 32'hffff_fff9, 32'd2, 1'b0);
        add_row(0, muldiv_pkg::REM, muldiv_pkg::MUL, 32'd7, 32'hffff_fffe, 1'b0);
        add_row(0, muldiv_pkg::DIVU, muldiv_pkg::MUL, 32'hffff_ffff, 32'd3, 1'b0);
        add_row(0, muldiv_pkg::REMU, muldiv_pkg::MUL, 32'hffff_ffff, 32'd7, 1'b0);
        add_row(0, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        add_row(0, muldiv_pkg::REM, muldiv_pkg::MUL, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        add_row(0, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'h1234_5678, 32'd0, 1'b0);
        add_row(0, muldiv_pkg::DIVU, muldiv_pkg::MUL, 32'h1234_5678, 32'd0, 1'b0);
        add_row(0, muldiv_pkg::REM, muldiv_pkg::MUL, 32'h8765_4321, 32'd0, 1'b0);
        add_row(0, muldiv_pkg::REMU, muldiv_pkg::MUL, 32'h8765_4321, 32'd0, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'hffff_fffd, 32'd5, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULH, 32'h8000_0000, 32'h8000_0000, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULH, 32'hffff_fffb, 32'd7, 1'b0);
        // after a mul write the next tie goes to the divider
        add_row(2, muldiv_pkg::REMU, muldiv_pkg::MULHU, 32'hdead_beef, 32'h0001_0003, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'd123, 32'd456, 1'b0);
        add_row(2, muldiv_pkg::REM, muldiv_pkg::MUL, 32'h7fff_ffff, 32'hffff_fff0, 1'b0);
        add_row(0, muldiv_pkg::DIV, muldiv_pkg::MUL, 32'd1000, 32'd7, 1'b1);
        add_row(0, muldiv_pkg::DIVU, muldiv_pkg::MUL, 32'd1000, 32'd7, 1'b0);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULHU, 32'h0bad_cafe, 32'd99, 1'b1);
        add_row(1, muldiv_pkg::DIV, muldiv_pkg::MULHU, 32'h0bad_cafe, 32'h9999_9999, 1'b0);
        for (int i = 0; i < 5; i++) begin
            logic [31:0] sel;
            sel = rand_bits(2);
            add_row(i % 2, muldiv_pkg::div_op_t'(4'b0001 << sel[1:0]),
                    muldiv_pkg::mul_op_t'(4'b0001 << sel[1:0]),
                    rand_bits(32), rand_bits(32), 1'b0);
        end

        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clk);

        for (int r = 0; r < n_rows; r++) begin
            if (row_abort[r]) begin
                run_abort(r);
            end else if (row_kind[r] == 0) begin
                run_div(r);
            end else if (row_kind[r] == 1) begin
                run_mul(r);
            end else begin
                run_both(r);
            end
            @(negedge clk);
        end

        if (fail_count == 0 && !u_dut.u_sva.sva_fail) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/muldiv_pkg.sv
div/exu_div.sv
mul/exu_mul.sv
src/wb_arbiter.sv
src/exu_muldiv.sv
test/exu_muldiv_assertions.sv
test/tb_exu_muldiv.sv

// File: Makefile
TOP := tb_exu_muldiv

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o vsim
	./obj_dir/vsim > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
